// File: exec_core.f
logic/exec_pkg.sv
logic/instr_decoder.sv
logic/regfile.sv
logic/alu.sv
logic/exec_core.sv
bench/exec_core_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the execute core testbench with Verilator and runs it.
# The exit status is the simulation's own status.

cd "$(dirname "$0")" || exit 1

if ! command -v verilator >/dev/null 2>&1; then
    echo "verilator was not found on the PATH"
    exit 1
fi

verilator --binary --timing \
    --timescale 1ns/10ps \
    --top-module exec_core_tb \
    -f exec_core.f \
    -o exec_core_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "Build failed with status $status"
    exit "$status"
fi

./obj_dir/exec_core_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit "$status"
fi

echo "Simulation finished cleanly"
exit 0

// File: bench/exec_core_tb.sv
`timescale 1ns/10ps

module exec_core_tb;

    localparam int cycle_limit = 2000; // Tests need about 600.

    logic                  clk;
    logic                  reset;
    logic                  instr_valid;
    exec_pkg::instr_word_u instr;
    exec_pkg::wb_t         wb;

    logic [31:0] model_regs [0:31]; // Entry 0 is never written.
    integer      seed;
    int          cycles = 0;

    exec_core DUT (
        .clk         (clk),
        .reset       (reset),
        .instr_valid (instr_valid),
        .instr       (instr),
        .wb          (wb)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("TEST FAIL");
            $fatal(1, "Timeout: the tests did not finish within %0d cycles.", cycle_limit);
        end
    end

    // --------------------
    // Encoding and model
    // --------------------
    function automatic logic [31:0] reg_form(input logic [6:0] f7, input int rb, input int ra,
                                             input logic [2:0] f3, input int rd);
        return {f7, 5'(rb), 5'(ra), f3, 5'(rd), exec_pkg::op_reg};
    endfunction

    function automatic logic [31:0] imm_form(input logic [11:0] imm, input int ra,
                                             input logic [2:0] f3, input int rd);
        return {imm, 5'(ra), f3, 5'(rd), exec_pkg::op_imm};
    endfunction

    function automatic int rand_reg();
        logic [31:0] r;
        r = $random(seed);
        return 1 + int'(r[4:0]) % 31; // Any of 1 to 31.
    endfunction

    // Expected report and result from the instruction rules.
    function automatic exec_pkg::wb_t predict(input logic [31:0] word);
        logic [6:0]    opc;
        logic [6:0]    f7;
        logic [2:0]    f3;
        logic [31:0]   a;
        logic [31:0]   b;
        logic [31:0]   res;
        logic          alt;
        logic          ill;
        exec_pkg::wb_t w;
        opc = word[6:0];
        f3  = word[14:12];
        f7  = word[31:25];
        a   = model_regs[word[19:15]];
        b   = '0;
        ill = 1'b0;
        if (opc == exec_pkg::op_reg) begin
            b   = model_regs[word[24:20]];
            alt = (f7 == 7'b0100000);
            ill = (f7 != 7'd0) && !alt;
        end else if (opc == exec_pkg::op_imm) begin
            b   = {{20{word[31]}}, word[31:20]};
            alt = word[30]; // Immediate bit 10.
            ill = (f3 == 3'b000) && (f7 == 7'b0100000);
        end else begin
            alt = 1'b0;
            ill = 1'b1;
        end
        case (f3)
            3'b000: res = (opc == exec_pkg::op_reg && alt) ? a - b : a + b;
            3'b001: res = a << b[4:0];
            3'b010: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b100: res = a ^ b;
            3'b101: res = alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'b110: res = a | b;
            3'b111: res = a & b;
            default: begin
                res = '0;
                ill = 1'b1;
            end
        endcase
        w.valid   = 1'b1;
        w.illegal = ill;
        w.rd      = ill ? 5'd0 : word[11:7];
        w.data    = ill ? 32'd0 : res;
        return w;
    endfunction

    // --------------------
    // Drive and check
    // --------------------
    task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                         input string what);
        if (actual !== expected) begin
            $display("error at time %0t: %s is %h, expected %h", $time, what, actual, expected);
            $display("TEST FAIL");
            $fatal(1, "Stopped at the first mismatch.");
        end
    endtask

    task automatic run_instr(input logic [31:0] word, input string what);
        exec_pkg::wb_t expected;
        expected    = predict(word);
        instr       = word;
        instr_valid = 1'b1;
        @(negedge clk);
        instr_valid = 1'b0;
        check(32'(wb.valid), 32'(expected.valid), {what, ": wb.valid"});
        check(32'(wb.illegal), 32'(expected.illegal), {what, ": wb.illegal"});
        check(32'(wb.rd), 32'(expected.rd), {what, ": wb.rd"});
        check(wb.data, expected.data, {what, ": wb.data"});
        if (!expected.illegal && expected.rd != 5'd0) begin
            model_regs[expected.rd] = expected.data;
        end
    endtask

    task automatic idle_cycle();
        logic [31:0] junk;
        junk        = $random(seed);
        instr       = junk; // Ignored while the strobe is low.
        instr_valid = 1'b0;
        @(negedge clk);
        check(32'(wb.valid), 32'd0, "idle: wb.valid");
        check(32'(wb.illegal), 32'd0, "idle: wb.illegal");
        check(32'(wb.rd), 32'd0, "idle: wb.rd");
        check(wb.data, 32'd0, "idle: wb.data");
    endtask

    task automatic read_back_all();
        for (int k = 1; k < 32; k++) begin
            run_instr(reg_form(7'd0, 0, k, exec_pkg::f3_add, 0), "read back");
        end
    endtask

    // --------------------
    // Tests
    // --------------------
    task automatic test_reset();
        check(32'(wb.valid), 32'd0, "wb.valid after reset");
        check(32'(wb.illegal), 32'd0, "wb.illegal after reset");
        for (int k = 0; k < 32; k++) begin
            run_instr(reg_form(7'd0, 0, k, exec_pkg::f3_add, 1), "read after reset");
        end
    endtask

    task automatic test_write_read();
        logic [31:0] rnd;
        logic [11:0] imm;
        for (int r = 1; r < 32; r++) begin
            rnd = $random(seed);
            imm = rnd[11:0];
            if (imm[11:5] == 7'b0100000) begin
                imm[10] = 1'b0; // Keep it a legal add.
            end
            run_instr(imm_form(imm, 0, exec_pkg::f3_add, r), "load immediate");
        end
        read_back_all();
        for (int r = 1; r < 32; r++) begin
            rnd = $random(seed);
            run_instr(imm_form({4'd0, rnd[7:0]}, 0, exec_pkg::f3_add, r), "load small");
            run_instr(imm_form({7'd0, rnd[12:8]}, r, exec_pkg::f3_sll, r), "shift small");
            run_instr(imm_form({8'd0, rnd[19:16]}, r, exec_pkg::f3_or, r), "or small");
        end
        read_back_all();
    endtask

    task automatic test_reg_functions();
        logic [6:0] f7;
        logic [2:0] f3;
        int         rd;
        run_instr(imm_form(12'hffb, 0, exec_pkg::f3_add, 1), "load -5");
        run_instr(imm_form(12'd3, 0, exec_pkg::f3_add, 2), "load 3");
        run_instr(reg_form(7'd0, 2, 1, exec_pkg::f3_slt, 3), "slt negative");
        run_instr(reg_form(7'd0, 1, 2, exec_pkg::f3_slt, 4), "slt positive");
        run_instr(reg_form(exec_pkg::f7_alt, 2, 1, exec_pkg::f3_srl, 5), "sra negative");
        run_instr(reg_form(7'd0, 2, 1, exec_pkg::f3_srl, 6), "srl negative");
        run_instr(reg_form(exec_pkg::f7_alt, 1, 2, exec_pkg::f3_add, 7), "sub");
        for (int n = 0; n < 90; n++) begin
            f7 = 7'd0;
            case (n % 9)
                0: f3 = exec_pkg::f3_add;
                1: begin
                    f3 = exec_pkg::f3_add;
                    f7 = exec_pkg::f7_alt;
                end
                2: f3 = exec_pkg::f3_and;
                3: f3 = exec_pkg::f3_or;
                4: f3 = exec_pkg::f3_xor;
                5: f3 = exec_pkg::f3_slt;
                6: f3 = exec_pkg::f3_sll;
                7: f3 = exec_pkg::f3_srl;
                default: begin
                    f3 = exec_pkg::f3_srl;
                    f7 = exec_pkg::f7_alt;
                end
            endcase
            rd = rand_reg();
            run_instr(reg_form(f7, rand_reg(), rand_reg(), f3, rd), "register function");
            run_instr(reg_form(7'd0, 0, rd, exec_pkg::f3_add, 0), "read after write");
        end
    endtask

    task automatic test_imm_functions();
        logic [31:0] rnd;
        logic [11:0] imm;
        logic [2:0]  f3;
        int          rd;
        run_instr(imm_form(12'hfff, 0, exec_pkg::f3_add, 8), "addi -1");
        run_instr(imm_form(12'h800, 0, exec_pkg::f3_add, 9), "addi -2048");
        run_instr(imm_form(12'h801, 8, exec_pkg::f3_add, 10), "addi -2047");
        run_instr(imm_form(12'hfff, 9, exec_pkg::f3_xor, 11), "xori -1");
        run_instr(imm_form(12'hfff, 9, exec_pkg::f3_slt, 12), "slti -1");
        run_instr(imm_form(12'h8f0, 8, exec_pkg::f3_and, 13), "andi negative");
        run_instr(imm_form(12'h01f, 8, exec_pkg::f3_sll, 14), "slli 31");
        run_instr(imm_form({7'b0100000, 5'd4}, 9, exec_pkg::f3_srl, 15), "srai 4");
        run_instr(imm_form(12'd4, 9, exec_pkg::f3_srl, 16), "srli 4");
        run_instr(imm_form(12'h0e5, 9, exec_pkg::f3_sll, 17), "slli upper bits");
        run_instr(imm_form(12'h3e3, 9, exec_pkg::f3_srl, 18), "srli upper bits");
        for (int n = 0; n < 40; n++) begin
            rnd = $random(seed);
            imm = rnd[11:0];
            case (n % 8)
                0: f3 = exec_pkg::f3_add;
                1: f3 = exec_pkg::f3_slt;
                2: f3 = exec_pkg::f3_xor;
                3: f3 = exec_pkg::f3_or;
                4: f3 = exec_pkg::f3_and;
                5: f3 = exec_pkg::f3_sll;
                6: begin
                    f3      = exec_pkg::f3_srl;
                    imm[10] = 1'b0;
                end
                default: begin
                    f3      = exec_pkg::f3_srl;
                    imm[10] = 1'b1;
                end
            endcase
            if (f3 == exec_pkg::f3_add && imm[11:5] == 7'b0100000) begin
                imm[10] = 1'b0;
            end
            rd = rand_reg();
            run_instr(imm_form(imm, rand_reg(), f3, rd), "immediate function");
            run_instr(reg_form(7'd0, 0, rd, exec_pkg::f3_add, 0), "read after write");
        end
    endtask

    task automatic test_reg_zero();
        run_instr(imm_form(12'd123, 5, exec_pkg::f3_add, 0), "addi to x0");
        run_instr(reg_form(7'd0, 6, 5, exec_pkg::f3_xor, 0), "xor to x0");
        run_instr(reg_form(7'd0, 0, 0, exec_pkg::f3_add, 7), "read x0");
        run_instr(reg_form(7'd0, 0, 0, exec_pkg::f3_or, 0), "read x0 both ports");
    endtask

    task automatic test_illegal();
        logic [31:0] rnd;
        rnd = $random(seed);
        run_instr({rnd[31:7], 7'b1111111}, "unknown opcode");
        run_instr(reg_form(7'b0000001, 2, 1, exec_pkg::f3_add, 3), "bad funct7 add");
        run_instr(reg_form(7'b1000000, 2, 1, exec_pkg::f3_srl, 4), "bad funct7 srl");
        run_instr(imm_form({exec_pkg::f7_alt, 5'd9}, 1, exec_pkg::f3_add, 5), "immediate sub");
        run_instr(reg_form(7'd0, 2, 1, 3'b011, 6), "unused funct3");
        run_instr(imm_form(12'd1, 1, 3'b011, 6), "unused immediate funct3");
        idle_cycle();
        idle_cycle();
        idle_cycle();
        read_back_all();
    endtask

    initial begin
        seed = 22161;
        for (int k = 0; k < 32; k++) begin
            model_regs[k] = '0;
        end
        reset       = 1'b1;
        instr_valid = 1'b1; // Reset must win over this write.
        instr       = imm_form(12'd100, 0, exec_pkg::f3_add, 5);
        repeat (15) @(posedge clk);
        @(negedge clk);
        instr = imm_form({exec_pkg::f7_alt, 5'd1}, 0, exec_pkg::f3_add, 5); // Illegal at last edge.
        @(posedge clk);
        @(negedge clk);
        reset       = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;

        test_reset();
        test_write_read();
        test_reg_functions();
        test_imm_functions();
        test_reg_zero();
        test_illegal();

        $display("TEST PASS");
        $finish;
    end

endmodule

// File: logic/exec_core.sv
`timescale 1ns/10ps

module exec_core (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  instr_valid,
    input  exec_pkg::instr_word_u instr,
    output exec_pkg::wb_t         wb
);

    exec_pkg::decode_t         dec;
    exec_pkg::wb_t             wb_next;
    logic [exec_pkg::xlen-1:0] ra_data;
    logic [exec_pkg::xlen-1:0] rb_data;
    logic [exec_pkg::xlen-1:0] op_b;
    logic [exec_pkg::xlen-1:0] result;
    logic                      accept;

    // --------------------
    // Decode and operands
    // --------------------
    instr_decoder u_decoder (
        .instr_valid (instr_valid),
        .instr       (instr),
        .dec         (dec)
    );

    regfile u_regfile (
        .clk    (clk),
        .reset  (reset),
        .rd     (dec.rd),
        .rd_in  (result),
        .ra     (dec.ra),
        .rb     (dec.rb),
        .ra_out (ra_data),
        .rb_out (rb_data)
    );

    assign op_b = dec.use_imm ? dec.imm : rb_data; // Immediate or second register.

    // --------------------
    // Execute
    // --------------------
    alu u_alu (
        .a      (ra_data),
        .b      (op_b),
        .func   (dec.func),
        .result (result)
    );

    assign accept = instr_valid && !dec.illegal;

    always_comb begin
        wb_next.valid   = instr_valid;
        wb_next.illegal = dec.illegal;
        wb_next.rd      = dec.rd;
        wb_next.data    = accept ? result : '0; // Zero on idle and rejected cycles.
    end

    // --------------------
    // Write-back report
    // --------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            wb <= '0;
        end else begin
            wb <= wb_next;
        end
    end

endmodule

// File: logic/alu.sv
`timescale 1ns/10ps

module alu (
    input  logic [exec_pkg::xlen-1:0] a,
    input  logic [exec_pkg::xlen-1:0] b,
    input  exec_pkg::alu_func_t       func,
    output logic [exec_pkg::xlen-1:0] result
);

    logic [4:0]                shamt;
    logic [exec_pkg::xlen-1:0] sum;
    logic [exec_pkg::xlen-1:0] diff;
    logic                      less;

    assign shamt = b[4:0]; // Shift amount from low bits only.
    assign sum   = a + b;
    assign diff  = a - b;
    assign less  = ($signed(a) < $signed(b));

    // --------------------
    // Function select
    // --------------------
    always_comb begin
        case (func)
            exec_pkg::alu_add: begin
                result = sum;
            end
            exec_pkg::alu_sub: begin
                result = diff;
            end
            exec_pkg::alu_and: begin
                result = a & b;
            end
            exec_pkg::alu_or: begin
                result = a | b;
            end
            exec_pkg::alu_xor: begin
                result = a ^ b;
            end
            exec_pkg::alu_slt: begin
                result = {{(exec_pkg::xlen-1){1'b0}}, less};
            end
            exec_pkg::alu_sll: begin
                result = a << shamt;
            end
            exec_pkg::alu_srl: begin
                result = a >> shamt;
            end
            exec_pkg::alu_sra: begin
                result = $signed(a) >>> shamt; // Sign fills from the left.
            end
            default: begin
                result = '0;
            end
        endcase
    end

endmodule

// File: logic/regfile.sv
`timescale 1ns/10ps

module regfile (
    input  logic                                clk,
    input  logic                                reset,
    input  logic [exec_pkg::reg_addr_width-1:0] rd,
    input  logic [exec_pkg::xlen-1:0]           rd_in,
    input  logic [exec_pkg::reg_addr_width-1:0] ra,
    input  logic [exec_pkg::reg_addr_width-1:0] rb,
    output logic [exec_pkg::xlen-1:0]           ra_out,
    output logic [exec_pkg::xlen-1:0]           rb_out
);

    // Register 0 is not stored.
    logic [exec_pkg::xlen-1:0] regs [1:exec_pkg::reg_count-1];

    // --------------------
    // Write port
    // --------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 1; i < exec_pkg::reg_count; i++) begin
                regs[i] <= '0;
            end
        end else if (rd != '0) begin
            regs[rd] <= rd_in;
        end
    end

    // --------------------
    // Read ports
    // --------------------
    always_comb begin
        if (ra == '0) begin
            ra_out = '0;
        end else begin
            ra_out = regs[ra];
        end
    end

    always_comb begin
        if (rb == '0) begin
            rb_out = '0;
        end else begin
            rb_out = regs[rb];
        end
    end

endmodule

// File: logic/instr_decoder.sv
`timescale 1ns/10ps

module instr_decoder (
    input  logic                  instr_valid,
    input  exec_pkg::instr_word_u instr,
    output exec_pkg::decode_t     dec
);

    logic [6:0]          opcode;
    logic [2:0]          funct3;
    logic [6:0]          funct7;
    logic                is_alt;
    logic                bad;
    exec_pkg::alu_func_t func;

    // Opcode and funct3 sit at the same place in both views.
    assign opcode = instr.r.opcode;
    assign funct3 = instr.r.funct3;
    assign funct7 = instr.r.funct7;
    assign is_alt = (funct7 == exec_pkg::f7_alt);

    // --------------------
    // Function decode
    // --------------------
    always_comb begin
        func = exec_pkg::alu_add;
        bad  = 1'b0;
        case (opcode)
            exec_pkg::op_reg: begin
                if (funct7 != 7'd0 && !is_alt) begin
                    bad = 1'b1;
                end
                case (funct3)
                    exec_pkg::f3_add: func = is_alt ? exec_pkg::alu_sub : exec_pkg::alu_add;
                    exec_pkg::f3_srl: func = is_alt ? exec_pkg::alu_sra : exec_pkg::alu_srl;
                    exec_pkg::f3_sll: func = exec_pkg::alu_sll;
                    exec_pkg::f3_slt: func = exec_pkg::alu_slt;
                    exec_pkg::f3_xor: func = exec_pkg::alu_xor;
                    exec_pkg::f3_or:  func = exec_pkg::alu_or;
                    exec_pkg::f3_and: func = exec_pkg::alu_and;
                    default:          bad  = 1'b1; // Unused funct3.
                endcase
            end
            exec_pkg::op_imm: begin
                case (funct3)
                    exec_pkg::f3_add: begin
                        // Upper immediate bits equal to f7_alt would mean sub.
                        bad = is_alt;
                    end
                    exec_pkg::f3_srl: begin
                        if (instr.i.imm[10]) begin
                            func = exec_pkg::alu_sra;
                        end else begin
                            func = exec_pkg::alu_srl;
                        end
                    end
                    exec_pkg::f3_sll: func = exec_pkg::alu_sll;
                    exec_pkg::f3_slt: func = exec_pkg::alu_slt;
                    exec_pkg::f3_xor: func = exec_pkg::alu_xor;
                    exec_pkg::f3_or:  func = exec_pkg::alu_or;
                    exec_pkg::f3_and: func = exec_pkg::alu_and;
                    default:          bad  = 1'b1;
                endcase
            end
            default: begin
                bad = 1'b1; // Unknown opcode.
            end
        endcase
    end

    // --------------------
    // Decoded fields
    // --------------------
    always_comb begin
        dec.ra      = instr.r.ra;
        dec.rb      = (opcode == exec_pkg::op_reg) ? instr.r.rb : '0;
        dec.use_imm = (opcode == exec_pkg::op_imm);
        dec.imm     = {{(exec_pkg::xlen - exec_pkg::imm_width){instr.i.imm[exec_pkg::imm_width-1]}},
                       instr.i.imm};
        dec.func    = func;
        dec.illegal = instr_valid && bad;
        dec.rd      = (instr_valid && !bad) ? instr.r.rd : '0; // Index 0 drops the write.
    end

endmodule

// File: logic/exec_pkg.sv
package exec_pkg;

    // --------------------
    // Sizes
    // --------------------
    localparam int xlen           = 32;
    localparam int reg_count      = 32;
    localparam int reg_addr_width = 5;
    localparam int imm_width      = 12;

    // Major opcodes.
    localparam logic [6:0] op_reg = 7'b0110011;
    localparam logic [6:0] op_imm = 7'b0010011;

    // Function fields.
    localparam logic [2:0] f3_add = 3'b000;
    localparam logic [2:0] f3_sll = 3'b001;
    localparam logic [2:0] f3_slt = 3'b010;
    localparam logic [2:0] f3_xor = 3'b100;
    localparam logic [2:0] f3_srl = 3'b101;
    localparam logic [2:0] f3_or  = 3'b110;
    localparam logic [2:0] f3_and = 3'b111;
    localparam logic [6:0] f7_alt = 7'b0100000;

    // --------------------
    // ALU functions
    // --------------------
    typedef logic [3:0] alu_func_t;

    localparam alu_func_t alu_add = 4'd0;
    localparam alu_func_t alu_sub = 4'd1;
    localparam alu_func_t alu_and = 4'd2;
    localparam alu_func_t alu_or  = 4'd3;
    localparam alu_func_t alu_xor = 4'd4;
    localparam alu_func_t alu_slt = 4'd5; // Signed.
    localparam alu_func_t alu_sll = 4'd6;
    localparam alu_func_t alu_srl = 4'd7;
    localparam alu_func_t alu_sra = 4'd8;

    // --------------------
    // Instruction word
    // --------------------
    typedef struct packed {
        logic [6:0]                funct7;
        logic [reg_addr_width-1:0] rb;
        logic [reg_addr_width-1:0] ra;
        logic [2:0]                funct3;
        logic [reg_addr_width-1:0] rd;
        logic [6:0]                opcode;
    } instr_r_t;

    typedef struct packed {
        logic [imm_width-1:0]      imm;
        logic [reg_addr_width-1:0] ra;
        logic [2:0]                funct3;
        logic [reg_addr_width-1:0] rd;
        logic [6:0]                opcode;
    } instr_i_t;

    typedef union packed {
        instr_r_t r;
        instr_i_t i;
    } instr_word_u;

    typedef struct packed {
        logic [reg_addr_width-1:0] ra;
        logic [reg_addr_width-1:0] rb;
        logic [reg_addr_width-1:0] rd; // Zero when nothing is written.
        logic                      use_imm;
        logic [xlen-1:0]           imm; // Sign-extended.
        alu_func_t                 func;
        logic                      illegal;
    } decode_t;

    typedef struct packed {
        logic                      valid;
        logic                      illegal;
        logic [reg_addr_width-1:0] rd;
        logic [xlen-1:0]           data;
    } wb_t;

endpackage
